/* testbench/video_regs_tests.txt */
// columns: op addr dsn data expected; op 1 cfg byte, 2 a write, 3 b write, 4 b read,
// 5 dma clear, 6 idle, 7 end of test (expected = pal_copy pulses); dsn 10 random, 08 clear
4 00 3 0000 0000
4 05 3 0000 0000
7 00 0 0000 0000
2 00 0 1234 0000
2 00 2 abcd 0000
2 00 1 5678 0000
2 03 3 ffff 0000
2 10 10 0000 0000
2 11 11 0000 0000
2 07 0 4321 0000
7 00 0 0000 0000
1 00 0 001f 0000
1 00 0 00ff 0000
1 00 0 0000 0000
1 00 0 0080 0000
1 00 0 002a 0000
1 00 0 0038 0000
1 00 0 0016 0000
1 00 0 000c 0000
1 00 0 0002 0000
1 00 0 0030 0000
1 00 0 002e 0000
1 00 0 002c 0000
1 00 0 002a 0000
1 00 0 0028 0000
1 00 0 0026 0000
1 00 0 0022 0000
1 00 0 0020 0000
1 00 0 0004 0000
1 00 0 0002 0000
1 00 0 00a5 0000
1 00 0 0032 0000
4 19 3 0000 0000
7 00 0 0000 0000
3 13 0 0abc 0000
3 14 1 1111 0000
3 14 2 2222 0000
3 15 10 0000 0000
3 18 0 0015 0000
4 13 3 0000 0000
4 14 3 0000 0000
4 15 3 0000 0000
4 18 3 0000 0000
4 1f 3 0000 0000
4 05 3 0000 0000
7 00 0 0000 0000
3 01 10 0000 0000
3 02 10 0000 0000
6 00 0 0000 0000
4 10 3 0000 0000
4 11 3 0000 0000
4 02 3 0000 0000
7 00 0 0000 0000
5 00 0 0000 0000
2 00 08 0000 0000
5 00 0 0000 0000
2 05 0 5a5a 0000
6 00 0 0000 0000
7 00 0 0000 0001

/* vlog.f */
src/video_regs_pkg.sv
src/cpsa_regs.sv
src/cpsb_cfg_chain.sv
src/cpsb_regs.sv
src/video_regs_top.sv
testbench/tb_video_regs.sv

/* Bender.yml */
package:
  name: video_regs

sources:
  - src/video_regs_pkg.sv
  - src/cpsa_regs.sv
  - src/cpsb_cfg_chain.sv
  - src/cpsb_regs.sv
  - src/video_regs_top.sv
  - target: test
    files:
      - testbench/tb_video_regs.sv

/* testbench/tb_video_regs.sv */
`timescale 1ns/10ps

module tb_video_regs;

    localparam int MAX_OPS = 256;
    localparam logic [15:0] OP_CFG  = 16'h1;
    localparam logic [15:0] OP_AWR  = 16'h2;
    localparam logic [15:0] OP_BWR  = 16'h3;
    localparam logic [15:0] OP_RD   = 16'h4;
    localparam logic [15:0] OP_CLR  = 16'h5;
    localparam logic [15:0] OP_IDLE = 16'h6;
    localparam logic [15:0] OP_END  = 16'h7;

    logic                      clk;
    logic                      reg_rst;
    video_regs_pkg::bus_t      bus;
    logic                      obj_dma_clr;
    logic                      cfg_we;
    video_regs_pkg::cfg_byte_t cfg_data;
    video_regs_pkg::word_t     rdata;
    logic                      obj_dma_ok;
    logic                      pal_copy;
    video_regs_pkg::cpsa_out_t cpsa;
    video_regs_pkg::cpsb_out_t cpsb;
    video_regs_pkg::cpsb_cfg_t cfg;

    // five hex fields per operation: op, addr, dsn and flags, data, expected
    logic [15:0] ops [0:5*MAX_OPS-1];
    int          n_ops = 0;
    int          cycles = 0;
    int          cycle_limit = 100;
    int          errors = 0;
    int          pal_count = 0;
    int          pal_mark = 0;
    int          test_num = 0;
    int          test_err0 = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    logic [31:0] lfsr = 32'hbdd48125;

    // reference model
    video_regs_pkg::word_t                m_a [0:17];
    video_regs_pkg::cfg_byte_t            m_chain [0:video_regs_pkg::CFG_BYTES-1];
    video_regs_pkg::word_t                m_layer;
    video_regs_pkg::word_t                m_prio [0:3];
    logic [video_regs_pkg::PAL_PAGES-1:0] m_pal;
    video_regs_pkg::word_t                m_mult1;
    video_regs_pkg::word_t                m_mult2;
    logic                                 m_dma;
    video_regs_pkg::word_t                m_rd;

    video_regs_top dut0 (
        .clk         (clk),
        .reg_rst     (reg_rst),
        .bus         (bus),
        .obj_dma_clr (obj_dma_clr),
        .cfg_we      (cfg_we),
        .cfg_data    (cfg_data),
        .rdata       (rdata),
        .obj_dma_ok  (obj_dma_ok),
        .pal_copy    (pal_copy),
        .cpsa        (cpsa),
        .cpsb        (cpsb),
        .cfg         (cfg)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        if (pal_copy === 1'b1) begin
            pal_count++;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_random_word(output video_regs_pkg::word_t w);
        int b;
        for (b = 0; b < 16; b++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[14:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input logic [511:0] got, input logic [511:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // word address of map field f; the chip id byte sits at position 1
    function automatic video_regs_pkg::reg_addr_t map_addr(input int f);
        int pos;
        pos = (f == 0) ? 0 : f + 1;
        return m_chain[pos][5:1];
    endfunction

    function automatic video_regs_pkg::word_t reg_value(input int f);
        logic [31:0] prod;
        prod = m_mult1 * m_mult2;
        case (f)
            // chip id nibbles land in bits 11:8 and 3:0
            0:       return {4'h0, m_chain[1][7:4], 4'h0, m_chain[1][3:0]};
            1:       return m_mult1;
            2:       return m_mult2;
            3:       return prod[15:0];
            4:       return prod[31:16];
            5:       return m_layer;
            10:      return {10'h000, m_pal};
            default: return m_prio[f-6];
        endcase
    endfunction

    function automatic video_regs_pkg::word_t model_read(input video_regs_pkg::reg_addr_t a);
        int f;
        int n;
        video_regs_pkg::word_t v;
        n = 0;
        v = video_regs_pkg::RD_IDLE;
        for (f = 0; f < 11; f++) begin
            if (a == map_addr(f)) begin
                n++;
                v = reg_value(f);
            end
        end
        if (n != 1 || a == 5'h1f) begin
            v = video_regs_pkg::RD_IDLE;
        end
        return v;
    endfunction

    function automatic video_regs_pkg::cpsa_out_t expect_cpsa();
        // struct order groups hpos before vpos, the bus interleaves them
        return {m_a[0], m_a[1], m_a[2], m_a[3], m_a[4], m_a[5], m_a[6], m_a[8], m_a[10],
                m_a[7], m_a[9], m_a[11], m_a[12], m_a[13], m_a[14], m_a[15], m_a[16], m_a[17]};
    endfunction

    function automatic video_regs_pkg::cpsb_cfg_t expect_cfg();
        video_regs_pkg::cpsb_cfg_t e;
        int f;
        for (f = 0; f < 11; f++) begin
            e.map[(10-f)*5 +: 5] = map_addr(f);
        end
        e.chip_id     = m_chain[1];
        e.layer_mask0 = m_chain[12];
        e.layer_mask1 = m_chain[13];
        e.layer_mask2 = m_chain[14];
        e.layer_mask3 = m_chain[15];
        e.game        = m_chain[16][5:0];
        e.bank_offset = {m_chain[18], m_chain[17]};
        e.bank_mask   = {m_chain[20], m_chain[19]};
        return e;
    endfunction

    task automatic check_state(input string where);
        video_regs_pkg::cpsb_out_t eb;
        eb.layer_ctrl  = m_layer;
        eb.prio0       = m_prio[0];
        eb.prio1       = m_prio[1];
        eb.prio2       = m_prio[2];
        eb.prio3       = m_prio[3];
        eb.pal_page_en = m_pal;
        check_value(cpsa, expect_cpsa(), {where, " cpsa registers"});
        check_value(cpsb, eb, {where, " cpsb registers"});
        check_value(cfg, expect_cfg(), {where, " configuration"});
        check_value(obj_dma_ok, m_dma, {where, " obj_dma_ok"});
    endtask

    task automatic update_model(input logic [15:0] op, input video_regs_pkg::reg_addr_t a,
                                input video_regs_pkg::byte_en_n_t dsn, input logic clr,
                                input video_regs_pkg::word_t d);
        int i;
        case (op)
            OP_CFG: begin
                for (i = video_regs_pkg::CFG_BYTES - 1; i > 0; i--) begin
                    m_chain[i] = m_chain[i-1];
                end
                m_chain[0] = d[7:0];
            end
            OP_AWR: begin
                if (a <= 5'h11 && !dsn[1]) begin
                    m_a[a][15:8] = d[15:8];
                end
                if (a <= 5'h11 && !dsn[0]) begin
                    m_a[a][7:0] = d[7:0];
                end
                if (a == 5'h00) begin
                    m_dma = 1'b1;
                end else if (clr) begin
                    m_dma = 1'b0;
                end
            end
            OP_BWR: begin
                if (dsn == 2'b00) begin
                    if (a == map_addr(1)) begin
                        m_mult1 = d;
                    end
                    if (a == map_addr(2)) begin
                        m_mult2 = d;
                    end
                    if (a == map_addr(5)) begin
                        m_layer = d;
                    end
                    for (i = 0; i < 4; i++) begin
                        if (a == map_addr(6 + i)) begin
                            m_prio[i] = d;
                        end
                    end
                    if (a == map_addr(10)) begin
                        m_pal = d[video_regs_pkg::PAL_PAGES-1:0];
                    end
                end
            end
            OP_CLR: m_dma = 1'b0;
            default: ;
        endcase
    endtask

    task automatic finish_test(input int exp_pulses);
        @(posedge clk);
        check_value(pal_count - pal_mark, exp_pulses, "pal_copy pulse count");
        pal_mark = pal_count;
        test_num++;
        if (errors == test_err0) begin
            n_pass++;
            $display("test %0d ok", test_num);
        end else begin
            n_fail++;
            $display("test %0d failed with %0d errors", test_num, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    task automatic apply_op(input int k);
        logic [15:0]                op;
        logic [15:0]                flags;
        video_regs_pkg::reg_addr_t  a;
        video_regs_pkg::byte_en_n_t dsn;
        video_regs_pkg::word_t      d;
        video_regs_pkg::word_t      exp_rd;
        string                      where;
        op = ops[5*k];
        a = ops[5*k+1][4:0];
        flags = ops[5*k+2];
        dsn = flags[1:0];
        d = ops[5*k+3];
        where = $sformatf("op %0d", k);
        if (flags[4]) begin
            draw_random_word(d);
        end
        if (op == OP_END) begin
            finish_test(ops[5*k+4]);
        end else begin
            exp_rd = model_read(a);
            @(posedge clk);
            case (op)
                OP_CFG: begin
                    cfg_we   <= 1'b1;
                    cfg_data <= d[7:0];
                end
                OP_AWR, OP_BWR, OP_RD: begin
                    bus.cs_a    <= (op == OP_AWR);
                    bus.cs_b    <= (op != OP_AWR);
                    bus.addr    <= a;
                    bus.dsn     <= (op == OP_RD) ? 2'b11 : dsn;
                    bus.wdata   <= d;
                    obj_dma_clr <= flags[3];
                end
                OP_CLR: obj_dma_clr <= 1'b1;
                OP_IDLE: ;
                default: begin
                    errors++;
                    $display("op %0d has an unknown opcode %0h", k, op);
                end
            endcase
            // the DUT takes the operation at this edge
            @(posedge clk);
            bus         <= '0;
            obj_dma_clr <= 1'b0;
            cfg_we      <= 1'b0;
            update_model(op, a, dsn, flags[3], d);
            // readback follows every chip-B access and holds in between
            if (op == OP_BWR || op == OP_RD) begin
                m_rd = exp_rd;
            end
            @(negedge clk);
            check_state(where);
            check_value(rdata, m_rd, {where, " readback"});
        end
    endtask

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reg_rst = 1'b1;
        bus = '0;
        obj_dma_clr = 1'b0;
        cfg_we = 1'b0;
        cfg_data = '0;
        $readmemh("testbench/video_regs_tests.txt", ops);
        while (n_ops < MAX_OPS && !$isunknown(ops[5*n_ops]) && ops[5*n_ops] != 0) begin
            n_ops++;
        end
        cycle_limit = 4 * n_ops + 100;
        for (int i = 0; i < 18; i++) begin
            m_a[i] = '0;
        end
        for (int i = 0; i < video_regs_pkg::CFG_BYTES; i++) begin
            m_chain[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            m_prio[i] = video_regs_pkg::PRIO_RST;
        end
        m_layer = video_regs_pkg::LAYER_CTRL_RST;
        m_pal = '1;
        m_mult1 = '0;
        m_mult2 = '0;
        m_dma = 1'b0;
        m_rd = video_regs_pkg::RD_IDLE;
        repeat (5) @(posedge clk);
        reg_rst <= 1'b0;
        @(negedge clk);
        check_state("reset");
        check_value(pal_copy, 1'b0, "reset pal_copy");
        check_value(rdata, video_regs_pkg::RD_IDLE, "reset rdata");
        test_err0 = errors;
        for (int k = 0; k < n_ops; k++) begin
            apply_op(k);
        end
        $display("%0d tests ok, %0d tests failed, %0d errors", n_pass, n_fail, errors);
        if (errors == 0 && n_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* src/video_regs_top.sv */
`timescale 1ns/10ps

module video_regs_top (
    input  logic                       clk,
    input  logic                       reg_rst,
    input  video_regs_pkg::bus_t       bus,
    input  logic                       obj_dma_clr,
    input  logic                       cfg_we,
    input  video_regs_pkg::cfg_byte_t  cfg_data,
    output video_regs_pkg::word_t      rdata,
    output logic                       obj_dma_ok,
    output logic                       pal_copy,
    output video_regs_pkg::cpsa_out_t  cpsa,
    output video_regs_pkg::cpsb_out_t  cpsb,
    output video_regs_pkg::cpsb_cfg_t  cfg
);

    // fixed map chip
    cpsa_regs u_cpsa_regs (
        .clk         (clk),
        .reg_rst     (reg_rst),
        .bus         (bus),
        .obj_dma_clr (obj_dma_clr),
        .regs        (cpsa),
        .obj_dma_ok  (obj_dma_ok),
        .pal_copy    (pal_copy)
    );

    // per-game setup loaded byte by byte
    cpsb_cfg_chain u_cpsb_cfg_chain (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .cfg      (cfg)
    );

    // configurable map chip, owns the readback
    cpsb_regs u_cpsb_regs (
        .clk     (clk),
        .reg_rst (reg_rst),
        .bus     (bus),
        .map     (cfg.map),
        .chip_id (cfg.chip_id),
        .regs    (cpsb),
        .rdata   (rdata)
    );

endmodule

/* src/cpsb_regs.sv */
`timescale 1ns/10ps

module cpsb_regs (
    input  logic                       clk,
    input  logic                       reg_rst,
    input  video_regs_pkg::bus_t       bus,
    input  video_regs_pkg::cpsb_map_t  map,
    input  video_regs_pkg::cfg_byte_t  chip_id,
    output video_regs_pkg::cpsb_out_t  regs,
    output video_regs_pkg::word_t      rdata
);

    logic [10:0]           hit;
    logic                  wr_en;
    video_regs_pkg::word_t mult1;
    video_regs_pkg::word_t mult2;
    video_regs_pkg::word_t rslt0;
    video_regs_pkg::word_t rslt1;
    video_regs_pkg::word_t rd_next;

    // one compare per mapped address
    assign hit = {
        bus.addr == map.pal_page,
        bus.addr == map.prio3,
        bus.addr == map.prio2,
        bus.addr == map.prio1,
        bus.addr == map.prio0,
        bus.addr == map.layer,
        bus.addr == map.rslt1,
        bus.addr == map.rslt0,
        bus.addr == map.mult2,
        bus.addr == map.mult1,
        bus.addr == map.id
    };

    // only full word writes reach these registers
    assign wr_en = bus.cs_b && (bus.dsn == 2'b00);

    // running product, refreshed every cycle
    always_ff @(posedge clk) begin
        {rslt1, rslt0} <= mult1 * mult2;
    end

    always_comb begin
        case (hit)
            11'h001: rd_next = {4'h0, chip_id[7:4], 4'h0, chip_id[3:0]};
            11'h002: rd_next = mult1;
            11'h004: rd_next = mult2;
            11'h008: rd_next = rslt0;
            11'h010: rd_next = rslt1;
            11'h020: rd_next = regs.layer_ctrl;
            11'h040: rd_next = regs.prio0;
            11'h080: rd_next = regs.prio1;
            11'h100: rd_next = regs.prio2;
            11'h200: rd_next = regs.prio3;
            11'h400: rd_next = {{(16-video_regs_pkg::PAL_PAGES){1'b0}}, regs.pal_page_en};
            // no match or an overlapping map
            default: rd_next = video_regs_pkg::RD_IDLE;
        endcase
        if (&bus.addr) begin
            rd_next = video_regs_pkg::RD_IDLE;
        end
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mult1            <= '0;
            mult2            <= '0;
            regs.layer_ctrl  <= video_regs_pkg::LAYER_CTRL_RST;
            regs.prio0       <= video_regs_pkg::PRIO_RST;
            regs.prio1       <= video_regs_pkg::PRIO_RST;
            regs.prio2       <= video_regs_pkg::PRIO_RST;
            regs.prio3       <= video_regs_pkg::PRIO_RST;
            regs.pal_page_en <= '1;
            rdata            <= video_regs_pkg::RD_IDLE;
        end else begin
            if (bus.cs_b) begin
                // readback shows the value ahead of this edge's write
                rdata <= rd_next;
            end
            if (wr_en && hit[1]) begin
                mult1 <= bus.wdata;
            end
            if (wr_en && hit[2]) begin
                mult2 <= bus.wdata;
            end
            if (wr_en && hit[5]) begin
                regs.layer_ctrl <= bus.wdata;
            end
            if (wr_en && hit[6]) begin
                regs.prio0 <= bus.wdata;
            end
            if (wr_en && hit[7]) begin
                regs.prio1 <= bus.wdata;
            end
            if (wr_en && hit[8]) begin
                regs.prio2 <= bus.wdata;
            end
            if (wr_en && hit[9]) begin
                regs.prio3 <= bus.wdata;
            end
            if (wr_en && hit[10]) begin
                regs.pal_page_en <= bus.wdata[video_regs_pkg::PAL_PAGES-1:0];
            end
        end
    end

endmodule

/* src/cpsb_cfg_chain.sv */
`timescale 1ns/10ps

module cpsb_cfg_chain (
    input  logic                       clk,
    input  logic                       reg_rst,
    input  logic                       cfg_we,
    input  video_regs_pkg::cfg_byte_t  cfg_data,
    output video_regs_pkg::cpsb_cfg_t  cfg
);

    video_regs_pkg::cfg_byte_t [video_regs_pkg::CFG_BYTES-1:0] chain;

    // byte addresses become word addresses
    function automatic video_regs_pkg::reg_addr_t to_word_addr(
        input video_regs_pkg::cfg_byte_t b
    );
        return b[5:1];
    endfunction

    // new byte enters at 0, first byte loaded ends at the top
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            chain <= '0;
        end else if (cfg_we) begin
            chain <= {chain[video_regs_pkg::CFG_BYTES-2:0], cfg_data};
        end
    end

    assign cfg.map.id       = to_word_addr(chain[0]);
    assign cfg.chip_id      = chain[1];
    assign cfg.map.mult1    = to_word_addr(chain[2]);
    assign cfg.map.mult2    = to_word_addr(chain[3]);
    assign cfg.map.rslt0    = to_word_addr(chain[4]);
    assign cfg.map.rslt1    = to_word_addr(chain[5]);
    assign cfg.map.layer    = to_word_addr(chain[6]);
    assign cfg.map.prio0    = to_word_addr(chain[7]);
    assign cfg.map.prio1    = to_word_addr(chain[8]);
    assign cfg.map.prio2    = to_word_addr(chain[9]);
    assign cfg.map.prio3    = to_word_addr(chain[10]);
    assign cfg.map.pal_page = to_word_addr(chain[11]);

    // layer enable masks per layer
    assign cfg.layer_mask0  = chain[12];
    assign cfg.layer_mask1  = chain[13];
    assign cfg.layer_mask2  = chain[14];
    assign cfg.layer_mask3  = chain[15];

    // rom banking, low byte first
    assign cfg.game         = chain[16][5:0];
    assign cfg.bank_offset  = {chain[18], chain[17]};
    assign cfg.bank_mask    = {chain[20], chain[19]};

endmodule

/* src/cpsa_regs.sv */
`timescale 1ns/10ps

module cpsa_regs (
    input  logic                   clk,
    input  logic                   reg_rst,
    input  video_regs_pkg::bus_t   bus,
    input  logic                   obj_dma_clr,
    output video_regs_pkg::cpsa_out_t regs,
    output logic                   obj_dma_ok,
    output logic                   pal_copy
);

    video_regs_pkg::word_t cur_word;
    video_regs_pkg::word_t wr_word;
    logic                  pal_pend;

    // keep the old byte wherever its enable is high
    function automatic video_regs_pkg::word_t merge_bytes(
        input video_regs_pkg::word_t      old_w,
        input video_regs_pkg::word_t      new_w,
        input video_regs_pkg::byte_en_n_t dsn
    );
        video_regs_pkg::word_t res;
        res[15:8] = dsn[1] ? old_w[15:8] : new_w[15:8];
        res[7:0]  = dsn[0] ? old_w[7:0]  : new_w[7:0];
        return res;
    endfunction

    // current value of the addressed register, for the byte merge
    always_comb begin
        case (bus.addr)
            5'h00:   cur_word = regs.obj_base;
            5'h01:   cur_word = regs.scr1_base;
            5'h02:   cur_word = regs.scr2_base;
            5'h03:   cur_word = regs.scr3_base;
            5'h04:   cur_word = regs.row_base;
            5'h05:   cur_word = regs.pal_base;
            5'h06:   cur_word = regs.hpos1;
            5'h07:   cur_word = regs.vpos1;
            5'h08:   cur_word = regs.hpos2;
            5'h09:   cur_word = regs.vpos2;
            5'h0a:   cur_word = regs.hpos3;
            5'h0b:   cur_word = regs.vpos3;
            5'h0c:   cur_word = regs.hstar1;
            5'h0d:   cur_word = regs.vstar1;
            5'h0e:   cur_word = regs.hstar2;
            5'h0f:   cur_word = regs.vstar2;
            5'h10:   cur_word = regs.row_offset;
            5'h11:   cur_word = regs.ppu_ctrl;
            default: cur_word = '0;
        endcase
    end

    assign wr_word = merge_bytes(cur_word, bus.wdata, bus.dsn);

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            regs       <= '0;
            obj_dma_ok <= 1'b0;
            pal_copy   <= 1'b0;
            pal_pend   <= 1'b0;
        end else begin
            // copy waits for the select to drop so pal_base is final
            pal_copy <= !bus.cs_a && pal_pend;
            if (!bus.cs_a && pal_pend) begin
                pal_pend <= 1'b0;
            end
            if (obj_dma_clr) begin
                obj_dma_ok <= 1'b0;
            end
            if (bus.cs_a) begin
                case (bus.addr)
                    5'h00: begin
                        regs.obj_base <= wr_word;
                        // a set at the same edge as a clear wins
                        obj_dma_ok    <= 1'b1;
                    end
                    5'h01: regs.scr1_base <= wr_word;
                    5'h02: regs.scr2_base <= wr_word;
                    5'h03: regs.scr3_base <= wr_word;
                    5'h04: regs.row_base  <= wr_word;
                    5'h05: begin
                        regs.pal_base <= wr_word;
                        pal_pend      <= 1'b1;
                    end
                    5'h06: regs.hpos1      <= wr_word;
                    5'h07: regs.vpos1      <= wr_word;
                    5'h08: regs.hpos2      <= wr_word;
                    5'h09: regs.vpos2      <= wr_word;
                    5'h0a: regs.hpos3      <= wr_word;
                    5'h0b: regs.vpos3      <= wr_word;
                    5'h0c: regs.hstar1     <= wr_word;
                    5'h0d: regs.vstar1     <= wr_word;
                    5'h0e: regs.hstar2     <= wr_word;
                    5'h0f: regs.vstar2     <= wr_word;
                    5'h10: regs.row_offset <= wr_word;
                    5'h11: regs.ppu_ctrl   <= wr_word;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* src/video_regs_pkg.sv */
package video_regs_pkg;

    // a register word and a CPU word address (address bits 5:1)
    typedef logic [15:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    // active low byte enables, bit 1 is the upper byte
    typedef logic [1:0]  byte_en_n_t;
    typedef logic [7:0]  cfg_byte_t;

    localparam int CFG_BYTES = 21;
    localparam int PAL_PAGES = 6;

    // layers 3,2,1,0 from the top of the order field down to bit 6
    localparam word_t LAYER_CTRL_RST = {2'b00, 2'd3, 2'd2, 2'd1, 2'd0, 6'd0};
    localparam word_t PRIO_RST       = 16'hffff;
    localparam word_t RD_IDLE        = 16'hffff;

    typedef struct packed {
        logic       cs_a;
        logic       cs_b;
        reg_addr_t  addr;
        byte_en_n_t dsn;
        word_t      wdata;
    } bus_t;

    typedef struct packed {
        // vram bases
        word_t obj_base;
        word_t scr1_base;
        word_t scr2_base;
        word_t scr3_base;
        word_t row_base;
        word_t pal_base;
        // scroll positions
        word_t hpos1;
        word_t hpos2;
        word_t hpos3;
        word_t vpos1;
        word_t vpos2;
        word_t vpos3;
        // star field
        word_t hstar1;
        word_t vstar1;
        word_t hstar2;
        word_t vstar2;
        word_t row_offset;
        word_t ppu_ctrl;
    } cpsa_out_t;

    // per-game register addresses of the second chip
    typedef struct packed {
        reg_addr_t id;
        reg_addr_t mult1;
        reg_addr_t mult2;
        reg_addr_t rslt0;
        reg_addr_t rslt1;
        reg_addr_t layer;
        reg_addr_t prio0;
        reg_addr_t prio1;
        reg_addr_t prio2;
        reg_addr_t prio3;
        reg_addr_t pal_page;
    } cpsb_map_t;

    typedef struct packed {
        cpsb_map_t  map;
        cfg_byte_t  chip_id;
        cfg_byte_t  layer_mask0;
        cfg_byte_t  layer_mask1;
        cfg_byte_t  layer_mask2;
        cfg_byte_t  layer_mask3;
        logic [5:0] game;
        word_t      bank_offset;
        word_t      bank_mask;
    } cpsb_cfg_t;

    typedef struct packed {
        word_t                layer_ctrl;
        word_t                prio0;
        word_t                prio1;
        word_t                prio2;
        word_t                prio3;
        logic [PAL_PAGES-1:0] pal_page_en;
    } cpsb_out_t;

endpackage
